/* branchPredictor.f */
hw/bpPkg.sv
hw/btbLookup.sv
hw/branchResolve.sv
hw/redirectPath.sv
hw/branchPredictor.sv
verification/tbClock.sv
verification/branchPredictor_checker.sv
verification/branchPredictor_tb.sv

/* hw/bpPkg.sv */
`default_nettype none

package bpPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and BTB geometry
    //////////////////////////////////////////////////////////////////////

    localparam int pcWidth = 32;

    // Direct-mapped BTB, word-aligned PCs
    localparam int btbIndexWidth = 4;
    localparam int btbEntries = 1 << btbIndexWidth;

    // Tag is everything above the index and the byte offset
    localparam int tagWidth = pcWidth - btbIndexWidth - 2;

    typedef logic [pcWidth-1:0] pcWord;

    // Sequential fetch step
    localparam pcWord pcStep = 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        strongNotTaken = 2'd0,
        weakNotTaken   = 2'd1,
        weakTaken      = 2'd2,
        strongTaken    = 2'd3
    } ctrState;

    // Fetch restart point after a resolution
    typedef enum logic [1:0] {
        npcSequential  = 2'd0,
        npcTarget      = 2'd1,
        npcFallThrough = 2'd2
    } npcSel;

endpackage

`default_nettype wire

/* hw/branchPredictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branchPredictor (
    input  logic            clk,
    input  logic            rst,

    // Fetch side
    input  bpPkg::pcWord    fetchPc,
    output bpPkg::pcWord    nextFetchPc,
    output logic            predHit,
    output logic            predTaken,
    output bpPkg::pcWord    predTarget,

    // Execute side
    input  logic            resolveValid,
    input  bpPkg::pcWord    resolvePc,
    input  logic            branchInstr,
    input  logic            jumpInstr,
    input  logic            jumpTaken,
    input  bpPkg::pcWord    actualTarget,
    input  logic            exPredHit,
    input  logic            exPredTaken,
    input  bpPkg::pcWord    exPredTarget,
    input  bpPkg::ctrState  exCtr,

    output logic            flushPipe,
    output bpPkg::npcSel    redirectSel
);

    import bpPkg::*;

    // Counter read at fetch, travels down the pipe and returns as exCtr
    ctrState predCtr;

    logic                     mispredict;
    npcSel                    npcChoice;
    logic                     btbWrite;
    logic [btbIndexWidth-1:0] btbWriteIndex;
    logic [tagWidth-1:0]      btbWriteTag;
    pcWord                    btbWriteTarget;
    ctrState                  btbWriteCtr;

    btbLookup u_btbLookup (
        .clk            (clk),
        .rst            (rst),
        .fetchPc        (fetchPc),
        .btbWrite       (btbWrite),
        .btbWriteIndex  (btbWriteIndex),
        .btbWriteTag    (btbWriteTag),
        .btbWriteTarget (btbWriteTarget),
        .btbWriteCtr    (btbWriteCtr),
        .predHit        (predHit),
        .predTaken      (predTaken),
        .predTarget     (predTarget),
        .predCtr        (predCtr)
    );

    branchResolve u_branchResolve (
        .resolveValid   (resolveValid),
        .resolvePc      (resolvePc),
        .branchInstr    (branchInstr),
        .jumpInstr      (jumpInstr),
        .jumpTaken      (jumpTaken),
        .actualTarget   (actualTarget),
        .exPredHit      (exPredHit),
        .exPredTaken    (exPredTaken),
        .exPredTarget   (exPredTarget),
        .exCtr          (exCtr),
        .mispredict     (mispredict),
        .npcChoice      (npcChoice),
        .btbWrite       (btbWrite),
        .btbWriteIndex  (btbWriteIndex),
        .btbWriteTag    (btbWriteTag),
        .btbWriteTarget (btbWriteTarget),
        .btbWriteCtr    (btbWriteCtr)
    );

    redirectPath u_redirectPath (
        .clk            (clk),
        .rst            (rst),
        .mispredict     (mispredict),
        .npcChoice      (npcChoice),
        .resolvePc      (resolvePc),
        .actualTarget   (actualTarget),
        .fetchPc        (fetchPc),
        .predTaken      (predTaken),
        .predTarget     (predTarget),
        .flushPipe      (flushPipe),
        .redirectSel    (redirectSel),
        .nextFetchPc    (nextFetchPc)
    );

endmodule

`default_nettype wire

/* hw/branchResolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    // Resolution from execute
    input  logic                             resolveValid,
    input  bpPkg::pcWord                     resolvePc,
    input  logic                             branchInstr,
    input  logic                             jumpInstr,
    input  logic                             jumpTaken,
    input  bpPkg::pcWord                     actualTarget,

    // Prediction carried down from fetch
    input  logic                             exPredHit,
    input  logic                             exPredTaken,
    input  bpPkg::pcWord                     exPredTarget,
    input  bpPkg::ctrState                   exCtr,

    // Toward the redirect path
    output logic                             mispredict,
    output bpPkg::npcSel                     npcChoice,

    // BTB update
    output logic                             btbWrite,
    output logic [bpPkg::btbIndexWidth-1:0]  btbWriteIndex,
    output logic [bpPkg::tagWidth-1:0]       btbWriteTag,
    output bpPkg::pcWord                     btbWriteTarget,
    output bpPkg::ctrState                   btbWriteCtr
);

    import bpPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Counter step
    //////////////////////////////////////////////////////////////////////

    // One step toward the outcome, holding at both ends
    function automatic ctrState stepCtr(input ctrState cur, input logic taken);
        ctrState nxt;
        case (cur)
            strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   nxt = taken ? weakTaken    : strongNotTaken;
            weakTaken:      nxt = taken ? strongTaken  : weakNotTaken;
            default:        nxt = taken ? strongTaken  : weakTaken;
        endcase
        return nxt;
    endfunction

    logic    predDir;
    logic    targetMatch;
    ctrState steppedCtr;
    logic [6:0] decodeKey;

    // A hit with a not-taken counter predicts fall-through
    assign predDir     = exPredHit && exPredTaken;
    assign targetMatch = (exPredTarget == actualTarget);
    assign steppedCtr  = stepCtr(exCtr, jumpTaken);

    // Entry location comes straight from the resolving PC
    assign btbWriteIndex = resolvePc[btbIndexWidth+1:2];
    assign btbWriteTag   = resolvePc[pcWidth-1:btbIndexWidth+2];

    // Keep the stored target on a not-taken hit
    assign btbWriteTarget = jumpTaken || jumpInstr ? actualTarget : exPredTarget;

    //////////////////////////////////////////////////////////////////////
    // Decision table
    //////////////////////////////////////////////////////////////////////

    // valid, jump, branch, hit, predicted taken, taken, target match
    assign decodeKey = {resolveValid, jumpInstr, branchInstr, exPredHit,
                        predDir, jumpTaken, targetMatch};

    always_comb
    begin
        mispredict  = 1'b0;
        npcChoice   = npcSequential;
        btbWrite    = 1'b0;
        btbWriteCtr = strongNotTaken;

        casez (decodeKey)
            // Idle or not a control transfer
            7'b0??????,
            7'b100????:
            begin
                btbWrite = 1'b0;
            end

            // Jump predicted with the right target
            7'b11??1?1:
            begin
                btbWrite    = 1'b1;
                btbWriteCtr = strongTaken;
            end

            // Any other jump
            7'b11?????:
            begin
                mispredict  = 1'b1;
                npcChoice   = npcTarget;
                btbWrite    = 1'b1;
                btbWriteCtr = strongTaken;
            end

            // Branch miss, taken, allocate
            7'b1010?1?:
            begin
                mispredict  = 1'b1;
                npcChoice   = npcTarget;
                btbWrite    = 1'b1;
                btbWriteCtr = weakTaken;
            end

            // Branch hit, predicted not taken
            7'b101100?:
            begin
                btbWrite    = 1'b1;
                btbWriteCtr = steppedCtr;
            end

            7'b101101?:
            begin
                mispredict  = 1'b1;
                npcChoice   = npcTarget;
                btbWrite    = 1'b1;
                btbWriteCtr = steppedCtr;
            end

            // Branch hit, predicted taken
            7'b101110?:
            begin
                mispredict  = 1'b1;
                npcChoice   = npcFallThrough;
                btbWrite    = 1'b1;
                btbWriteCtr = steppedCtr;
            end

            7'b1011110:
            begin
                mispredict  = 1'b1;
                npcChoice   = npcTarget;
                btbWrite    = 1'b1;
                btbWriteCtr = steppedCtr;
            end

            7'b1011111:
            begin
                btbWrite    = 1'b1;
                btbWriteCtr = steppedCtr;
            end

            // Not-taken miss leaves the BTB alone
            default:
            begin
                btbWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/btbLookup.sv */
`timescale 1ns/1ps
`default_nettype none

module btbLookup (
    input  logic                             clk,
    input  logic                             rst,

    // Fetch lookup
    input  bpPkg::pcWord                     fetchPc,

    // Write port from the resolution logic
    input  logic                             btbWrite,
    input  logic [bpPkg::btbIndexWidth-1:0]  btbWriteIndex,
    input  logic [bpPkg::tagWidth-1:0]       btbWriteTag,
    input  bpPkg::pcWord                     btbWriteTarget,
    input  bpPkg::ctrState                   btbWriteCtr,

    // Prediction toward fetch
    output logic                             predHit,
    output logic                             predTaken,
    output bpPkg::pcWord                     predTarget,
    output bpPkg::ctrState                   predCtr
);

    import bpPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    logic [btbEntries-1:0] validBits;
    logic [tagWidth-1:0]   tagMem    [btbEntries];
    pcWord                 targetMem [btbEntries];
    ctrState               ctrMem    [btbEntries];

    // Fetch PC split
    logic [btbIndexWidth-1:0] fetchIndex;
    logic [tagWidth-1:0]      fetchTag;

    // Selected entry
    logic                     entryValid;
    logic [tagWidth-1:0]      entryTag;
    pcWord                    entryTarget;
    ctrState                  entryCtr;

    assign fetchIndex = fetchPc[btbIndexWidth+1:2];
    assign fetchTag   = fetchPc[pcWidth-1:btbIndexWidth+2];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    // Valid bits mark the written entries
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            validBits <= '0;
        end
        else if (btbWrite)
        begin
            validBits[btbWriteIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (btbWrite)
        begin
            tagMem[btbWriteIndex]    <= btbWriteTag;
            targetMem[btbWriteIndex] <= btbWriteTarget;
            ctrMem[btbWriteIndex]    <= btbWriteCtr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    // Read is asynchronous, so a same-cycle write is seen one cycle later
    assign entryValid  = validBits[fetchIndex];
    assign entryTag    = tagMem[fetchIndex];
    assign entryTarget = targetMem[fetchIndex];
    assign entryCtr    = ctrMem[fetchIndex];

    always_comb
    begin
        predHit    = entryValid && (entryTag == fetchTag);
        predTaken  = 1'b0;
        predTarget = '0;
        predCtr    = strongNotTaken;

        if (predHit)
        begin
            // Upper counter bit gives the direction
            predTaken  = entryCtr[1];
            predTarget = entryTarget;
            predCtr    = entryCtr;
        end
    end

endmodule

`default_nettype wire

/* hw/redirectPath.sv */
`timescale 1ns/1ps
`default_nettype none

module redirectPath (
    input  logic            clk,
    input  logic            rst,

    // From the resolution logic
    input  logic            mispredict,
    input  bpPkg::npcSel    npcChoice,
    input  bpPkg::pcWord    resolvePc,
    input  bpPkg::pcWord    actualTarget,

    // Fetch prediction path
    input  bpPkg::pcWord    fetchPc,
    input  logic            predTaken,
    input  bpPkg::pcWord    predTarget,

    output logic            flushPipe,
    output bpPkg::npcSel    redirectSel,
    output bpPkg::pcWord    nextFetchPc
);

    import bpPkg::*;

    logic  flushReg;
    npcSel selReg;
    pcWord redirectPc;
    pcWord redirectPcReg;
    pcWord predictedPc;

    // Restart address chosen in the resolve cycle
    assign redirectPc = (npcChoice == npcFallThrough) ? resolvePc + pcStep : actualTarget;

    //////////////////////////////////////////////////////////////////////
    // Registered flush and redirect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flushReg <= 1'b0;
            selReg   <= npcSequential;
        end
        else
        begin
            flushReg <= mispredict;
            selReg   <= npcChoice;
        end
    end

    always_ff @(posedge clk)
    begin
        redirectPcReg <= redirectPc;
    end

    assign flushPipe   = flushReg;
    assign redirectSel = selReg;

    //////////////////////////////////////////////////////////////////////
    // Next fetch PC
    //////////////////////////////////////////////////////////////////////

    assign predictedPc = predTaken ? predTarget : fetchPc + pcStep;

    // Flush overrides whatever fetch predicted this cycle
    assign nextFetchPc = flushReg ? redirectPcReg : predictedPc;

endmodule

`default_nettype wire

/* verification/branchPredictor_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module branchPredictor_checker (
    input logic               clk,
    input logic               rst,
    input logic               resolveValid,
    input logic               branchInstr,
    input logic               jumpInstr,
    input logic               flushPipe,
    input bpPkg::npcSel       redirectSel
);

    import bpPkg::*;

    // A flush always traces back to a resolution one cycle earlier
    noIdleFlush: assert property (@(posedge clk) disable iff (rst)
        !resolveValid |=> !flushPipe)
        else $error("flushPipe high after a cycle without resolveValid");

    // Non-control instructions never redirect fetch
    plainInstrNoRedirect: assert property (@(posedge clk) disable iff (rst)
        (resolveValid && !branchInstr && !jumpInstr) |=> (redirectSel == npcSequential))
        else $error("redirectSel not sequential after a non-branch resolution");

    // A flush carries a restart point and only a flush does
    flushMatchesSel: assert property (@(posedge clk) disable iff (rst)
        flushPipe == (redirectSel != npcSequential))
        else $error("flushPipe and redirectSel disagree");

endmodule

bind branchPredictor branchPredictor_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .resolveValid (resolveValid),
    .branchInstr  (branchInstr),
    .jumpInstr    (jumpInstr),
    .flushPipe    (flushPipe),
    .redirectSel  (redirectSel)
);

`default_nettype wire

/* verification/branchPredictor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module branchPredictor_tb;

    import bpPkg::*;

    // One resolution followed by one checked lookup
    typedef struct packed {
        logic    valid;
        logic    br;
        logic    jmp;
        logic    taken;
        pcWord   resolvePc;
        pcWord   target;
        pcWord   fetchPc;
        logic    expFlush;
        npcSel   expSel;
        pcWord   lookPc;
        logic    expHit;
        logic    expTaken;
        pcWord   expTarget;
        ctrState expCtr;
    } stimRow;

    logic    clk;
    logic    rst;
    pcWord   fetchPc;
    pcWord   nextFetchPc;
    logic    predHit;
    logic    predTaken;
    pcWord   predTarget;
    logic    resolveValid;
    pcWord   resolvePc;
    logic    branchInstr;
    logic    jumpInstr;
    logic    jumpTaken;
    pcWord   actualTarget;
    logic    exPredHit;
    logic    exPredTaken;
    pcWord   exPredTarget;
    ctrState exCtr;
    logic    flushPipe;
    npcSel   redirectSel;

    stimRow rows[$];
    int     checks = 0;
    int     errors = 0;
    int     cycleCount = 0;
    int     timeoutLimit = 0;

    // Reference BTB contents
    logic                mValid  [btbEntries];
    logic [tagWidth-1:0] mTag    [btbEntries];
    pcWord               mTarget [btbEntries];
    ctrState             mCtr    [btbEntries];

    tbClock u_clock (
        .clk (clk),
        .rst (rst)
    );

    branchPredictor u_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkPc(input string name, input pcWord got, input pcWord exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkSel(input string name, input npcSel got, input npcSel exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkCtr(input string name, input ctrState got, input ctrState exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic addRow(input logic v, input logic br, input logic jmp, input logic tk,
                          input pcWord rPc, input pcWord aTgt, input pcWord fPc,
                          input logic eFlush, input npcSel eSel, input pcWord lPc,
                          input logic eHit, input logic eTk, input pcWord eTgt,
                          input ctrState eCtr);
        stimRow r;
        r = '{v, br, jmp, tk, rPc, aTgt, fPc, eFlush, eSel, lPc, eHit, eTk, eTgt, eCtr};
        rows.push_back(r);
    endtask

    // Entry update for a resolved jump or branch
    task automatic updateModel(input stimRow r, input logic [btbIndexWidth-1:0] idx,
                               input logic hit);
        if (r.jmp || (r.br && r.taken && !hit))
        begin
            mValid[idx]  = 1'b1;
            mTag[idx]    = r.resolvePc[pcWidth-1:btbIndexWidth+2];
            mTarget[idx] = r.target;
            mCtr[idx]    = r.jmp ? strongTaken : weakTaken;
        end
        else if (r.br && hit)
        begin
            if (r.taken)
                mTarget[idx] = r.target;
            if (r.taken && mCtr[idx] != strongTaken)
                mCtr[idx] = ctrState'(mCtr[idx] + 2'd1);
            else if (!r.taken && mCtr[idx] != strongNotTaken)
                mCtr[idx] = ctrState'(mCtr[idx] - 2'd1);
        end
    endtask

    task automatic runRow(input int n);
        stimRow                   r;
        logic [btbIndexWidth-1:0] idx;
        logic                     hit;
        pcWord                    expNext;
        int                       errBefore;
        r         = rows[n];
        idx       = r.resolvePc[btbIndexWidth+1:2];
        hit       = mValid[idx] && (mTag[idx] == r.resolvePc[pcWidth-1:btbIndexWidth+2]);
        errBefore = errors;

        // Resolve cycle, prediction fields as fetch would have seen them
        @(negedge clk);
        fetchPc      = r.fetchPc;
        resolveValid = r.valid;
        resolvePc    = r.resolvePc;
        branchInstr  = r.br;
        jumpInstr    = r.jmp;
        jumpTaken    = r.taken;
        actualTarget = r.target;
        exPredHit    = hit;
        exPredTaken  = hit && mCtr[idx][1];
        exPredTarget = hit ? mTarget[idx] : '0;
        exCtr        = hit ? mCtr[idx] : strongNotTaken;
        if (r.valid)
            updateModel(r, idx, hit);

        // Follow-up lookup while the registered flush is visible
        @(negedge clk);
        resolveValid = 1'b0;
        fetchPc      = r.lookPc;
        if (r.expFlush)
            expNext = (r.expSel == npcFallThrough) ? r.resolvePc + 32'd4 : r.target;
        else
            expNext = r.expTaken ? r.expTarget : r.lookPc + 32'd4;

        // Sample mid-cycle, well clear of the next rising edge
        #10;
        checkBit("flushPipe", flushPipe, r.expFlush);
        checkSel("redirectSel", redirectSel, r.expSel);
        checkBit("predHit", predHit, r.expHit);
        checkBit("predTaken", predTaken, r.expTaken);
        checkPc("predTarget", predTarget, r.expTarget);
        checkCtr("predCtr", u_dut.predCtr, r.expCtr);
        checkPc("nextFetchPc", nextFetchPc, expNext);
        $display("row %0d finished, %0d mismatches", n, errors - errBefore);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
        begin
            $display("run did not finish within %0d cycles", timeoutLimit);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        fetchPc      = '0;
        resolveValid = 1'b0;
        resolvePc    = '0;
        branchInstr  = 1'b0;
        jumpInstr    = 1'b0;
        jumpTaken    = 1'b0;
        actualTarget = '0;
        exPredHit    = 1'b0;
        exPredTaken  = 1'b0;
        exPredTarget = '0;
        exCtr        = strongNotTaken;
        for (int i = 0; i < btbEntries; i++)
            mValid[i] = 1'b0;

        // v br jmp tk resolvePc target fetchPc | flush sel | lookup hit tk target ctr
        addRow(0, 0, 0, 0, 'h000, 'h000, 'h100, 0, npcSequential, 'h100, 0, 0, 'h0, strongNotTaken);
        addRow(1, 0, 0, 0, 'h308, 'h500, 'h104, 0, npcSequential, 'h308, 0, 0, 'h0, strongNotTaken);
        addRow(1, 1, 0, 1, 'h100, 'h400, 'h30c, 1, npcTarget, 'h100, 1, 1, 'h400, weakTaken);
        addRow(1, 1, 0, 1, 'h100, 'h400, 'h400, 0, npcSequential, 'h100, 1, 1, 'h400, strongTaken);
        addRow(1, 1, 0, 1, 'h100, 'h400, 'h400, 0, npcSequential, 'h100, 1, 1, 'h400, strongTaken);
        addRow(1, 1, 0, 0, 'h100, 'h104, 'h400, 1, npcFallThrough, 'h100, 1, 1, 'h400, weakTaken);
        addRow(1, 1, 0, 0, 'h100, 'h104, 'h104, 1, npcFallThrough, 'h100, 1, 0, 'h400, weakNotTaken);
        addRow(1, 1, 0, 0, 'h100, 'h104, 'h104, 0, npcSequential, 'h100, 1, 0, 'h400, strongNotTaken);
        addRow(1, 1, 0, 0, 'h100, 'h104, 'h104, 0, npcSequential, 'h100, 1, 0, 'h400, strongNotTaken);
        addRow(1, 1, 0, 1, 'h100, 'h400, 'h104, 1, npcTarget, 'h100, 1, 0, 'h400, weakNotTaken);
        addRow(1, 0, 1, 1, 'h204, 'h600, 'h400, 1, npcTarget, 'h204, 1, 1, 'h600, strongTaken);
        addRow(1, 0, 1, 1, 'h204, 'h700, 'h600, 1, npcTarget, 'h204, 1, 1, 'h700, strongTaken);
        addRow(1, 0, 1, 1, 'h204, 'h700, 'h700, 0, npcSequential, 'h204, 1, 1, 'h700, strongTaken);
        addRow(1, 1, 0, 0, 'h10c, 'h110, 'h704, 0, npcSequential, 'h10c, 0, 0, 'h0, strongNotTaken);
        addRow(1, 0, 0, 0, 'h204, 'h900, 'h110, 0, npcSequential, 'h204, 1, 1, 'h700, strongTaken);
        addRow(0, 0, 0, 0, 'h000, 'h000, 'h700, 0, npcSequential, 'h308, 0, 0, 'h0, strongNotTaken);
        // Same index as 'h100 but a different tag
        addRow(0, 0, 0, 0, 'h000, 'h000, 'h30c, 0, npcSequential, 'h1100, 0, 0, 'h0, strongNotTaken);
        timeoutLimit = rows.size() * 4 + 10;

        wait (!rst);
        for (int n = 0; n < rows.size(); n++)
            runRow(n);

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        // Hold reset over three rising edges
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    // 100 ns period
    always #50 clk = ~clk;

endmodule

`default_nettype wire
